/* Makefile */
# Verilator simulation of the memory island testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -O2
TOP       ?= mem_island_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# $fatal in the testbench gives a non-zero exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
rtl/mem_island_pkg.sv
rtl/sram_bank.sv
rtl/wide_splitter.sv
rtl/wide_narrow_arbiter.sv
rtl/tcdm_xbar.sv
rtl/mem_island_core.sv
verif/mem_island_tb.sv

/* rtl/mem_island_core.sv */
// Memory island top level, narrow and wide crossbars, pair arbiter,
// wide splitters, bank access multiplexer and SRAM banks
`timescale 1ns/1ps

module mem_island_core (
    input  logic                                                        clk_i,
    input  logic                                                        reset_i,
    input  mem_island_pkg::narrow_req_t [mem_island_pkg::NUM_NARROW_PORTS-1:0] narrow_req_i,
    output mem_island_pkg::narrow_rsp_t [mem_island_pkg::NUM_NARROW_PORTS-1:0] narrow_rsp_o,
    input  mem_island_pkg::wide_req_t   [mem_island_pkg::NUM_WIDE_PORTS-1:0]   wide_req_i,
    output mem_island_pkg::wide_rsp_t   [mem_island_pkg::NUM_WIDE_PORTS-1:0]   wide_rsp_o
);

    // Crossbar outputs, one per bank
    mem_island_pkg::narrow_req_t [mem_island_pkg::NUM_NARROW_BANKS-1:0] narrow_bank_req;
    mem_island_pkg::wide_req_t   [mem_island_pkg::NUM_WIDE_BANKS-1:0]   wide_bank_req;
    // Wide requests cut into lanes
    mem_island_pkg::narrow_req_t [mem_island_pkg::NUM_WIDE_BANKS-1:0]
                                 [mem_island_pkg::WIDE_FACTOR-1:0]       split_req;
    // What each bank actually sees
    mem_island_pkg::narrow_req_t [mem_island_pkg::NUM_NARROW_BANKS-1:0] bank_req;

    logic [mem_island_pkg::NUM_NARROW_BANKS-1:0][mem_island_pkg::NARROW_WIDTH-1:0] bank_rdata;
    logic [mem_island_pkg::NUM_WIDE_BANKS-1:0][mem_island_pkg::WIDE_WIDTH-1:0]     wide_rdata;

    logic [mem_island_pkg::NUM_NARROW_BANKS-1:0] narrow_valid;
    logic [mem_island_pkg::NUM_NARROW_BANKS-1:0] narrow_ready;
    logic [mem_island_pkg::NUM_WIDE_BANKS-1:0]   wide_valid;
    logic [mem_island_pkg::NUM_WIDE_BANKS-1:0]   wide_ready;

    // ------------------------------------------------------------------------
    // Crossbars
    // ------------------------------------------------------------------------
    tcdm_xbar #(
        .NUM_IN    (mem_island_pkg::NUM_NARROW_PORTS),
        .NUM_OUT   (mem_island_pkg::NUM_NARROW_BANKS),
        .WIDE_VIEW (1'b0),
        .req_t     (mem_island_pkg::narrow_req_t),
        .rsp_t     (mem_island_pkg::narrow_rsp_t)
    ) u_narrow_xbar (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .req_i        (narrow_req_i),
        .rsp_o        (narrow_rsp_o),
        .bank_req_o   (narrow_bank_req),
        .bank_ready_i (narrow_ready),
        .bank_rdata_i (bank_rdata)
    );

    tcdm_xbar #(
        .NUM_IN    (mem_island_pkg::NUM_WIDE_PORTS),
        .NUM_OUT   (mem_island_pkg::NUM_WIDE_BANKS),
        .WIDE_VIEW (1'b1),
        .req_t     (mem_island_pkg::wide_req_t),
        .rsp_t     (mem_island_pkg::wide_rsp_t)
    ) u_wide_xbar (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .req_i        (wide_req_i),
        .rsp_o        (wide_rsp_o),
        .bank_req_o   (wide_bank_req),
        .bank_ready_i (wide_ready),
        .bank_rdata_i (wide_rdata)
    );

    // ------------------------------------------------------------------------
    // Narrow/wide arbitration
    // ------------------------------------------------------------------------
    for (genvar i = 0; i < mem_island_pkg::NUM_NARROW_BANKS; i++) begin : g_nvalid
        assign narrow_valid[i] = narrow_bank_req[i].valid;
    end

    for (genvar w = 0; w < mem_island_pkg::NUM_WIDE_BANKS; w++) begin : g_wvalid
        assign wide_valid[w] = wide_bank_req[w].valid;
    end

    wide_narrow_arbiter u_arbiter (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .narrow_valid_i (narrow_valid),
        .wide_valid_i   (wide_valid),
        .narrow_ready_o (narrow_ready),
        .wide_ready_o   (wide_ready)
    );

    // Splitters, one per bank pair
    for (genvar w = 0; w < mem_island_pkg::NUM_WIDE_BANKS; w++) begin : g_split
        wide_splitter u_splitter (
            .wide_req_i   (wide_bank_req[w]),
            .bank_req_o   (split_req[w]),
            .bank_rdata_i (bank_rdata[w*mem_island_pkg::WIDE_FACTOR +:
                                      mem_island_pkg::WIDE_FACTOR]),
            .wide_rdata_o (wide_rdata[w])
        );
    end

    // ------------------------------------------------------------------------
    // Bank access multiplexer
    // ------------------------------------------------------------------------
    // narrow_ready low means the wide side owns the pair this cycle
    always_comb begin
        for (int i = 0; i < mem_island_pkg::NUM_NARROW_BANKS; i++) begin
            if (narrow_ready[i]) begin
                bank_req[i] = narrow_bank_req[i];
            end else begin
                bank_req[i] = split_req[i / mem_island_pkg::WIDE_FACTOR]
                                       [i % mem_island_pkg::WIDE_FACTOR];
            end
        end
    end

    // Banks, read data fans back out to both crossbars
    for (genvar i = 0; i < mem_island_pkg::NUM_NARROW_BANKS; i++) begin : g_bank
        sram_bank u_bank (
            .clk_i   (clk_i),
            .req_i   (bank_req[i]),
            .rdata_o (bank_rdata[i])
        );
    end

endmodule

/* rtl/mem_island_pkg.sv */
// Shared constants, the dual-view address union and the narrow and wide
// request/response structs of the memory island
package mem_island_pkg;

    // ------------------------------------------------------------------------
    // Geometry
    // ------------------------------------------------------------------------
    localparam int unsigned ADDR_WIDTH       = 10;
    localparam int unsigned NARROW_WIDTH     = 32;
    localparam int unsigned WIDE_WIDTH       = 64;
    localparam int unsigned NUM_NARROW_BANKS = 4;
    localparam int unsigned NUM_WIDE_BANKS   = 2;
    localparam int unsigned WIDE_FACTOR      = 2;
    localparam int unsigned WORDS_PER_BANK   = 64;
    localparam int unsigned BANK_ADDR_WIDTH  = 6;
    localparam int unsigned NUM_NARROW_PORTS = 2;
    localparam int unsigned NUM_WIDE_PORTS   = 2;

    // Derived field widths
    localparam int unsigned NARROW_STRB_WIDTH = NARROW_WIDTH / 8;
    localparam int unsigned WIDE_STRB_WIDTH   = WIDE_WIDTH / 8;
    localparam int unsigned NARROW_SEL_WIDTH  = $clog2(NUM_NARROW_BANKS);
    localparam int unsigned WIDE_SEL_WIDTH    = $clog2(NUM_WIDE_BANKS);
    // Lane index inside a wide bank pair
    localparam int unsigned LANE_SEL_WIDTH    = $clog2(WIDE_FACTOR);
    localparam int unsigned NARROW_OFF_WIDTH  = ADDR_WIDTH - BANK_ADDR_WIDTH - NARROW_SEL_WIDTH;
    localparam int unsigned WIDE_OFF_WIDTH    = ADDR_WIDTH - BANK_ADDR_WIDTH - WIDE_SEL_WIDTH;

    // ------------------------------------------------------------------------
    // Address views
    // ------------------------------------------------------------------------
    // Narrow view, word | bank(2) | byte offset(2)
    typedef struct packed {
        logic [BANK_ADDR_WIDTH-1:0]  word;
        logic [NARROW_SEL_WIDTH-1:0] bank;
        logic [NARROW_OFF_WIDTH-1:0] offset;
    } narrow_addr_t;

    // Wide view, word | pair select(1) | byte offset(3)
    typedef struct packed {
        logic [BANK_ADDR_WIDTH-1:0] word;
        logic [WIDE_SEL_WIDTH-1:0]  bank;
        logic [WIDE_OFF_WIDTH-1:0]  offset;
    } wide_addr_t;

    // Same address word, decoded by whichever crossbar sees it
    typedef union packed {
        narrow_addr_t narrow;
        wide_addr_t   wide;
    } mem_addr_u;

    // ------------------------------------------------------------------------
    // Requests and responses
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic                         valid;
        logic                         write;
        mem_addr_u                    addr;
        logic [NARROW_WIDTH-1:0]      wdata;
        logic [NARROW_STRB_WIDTH-1:0] strb;
    } narrow_req_t;

    typedef struct packed {
        logic                    gnt;
        logic                    rvalid;
        logic [NARROW_WIDTH-1:0] rdata;
    } narrow_rsp_t;

    typedef struct packed {
        logic                       valid;
        logic                       write;
        mem_addr_u                  addr;
        logic [WIDE_WIDTH-1:0]      wdata;
        logic [WIDE_STRB_WIDTH-1:0] strb;
    } wide_req_t;

    typedef struct packed {
        logic                  gnt;
        logic                  rvalid;
        logic [WIDE_WIDTH-1:0] rdata;
    } wide_rsp_t;

endpackage

/* rtl/sram_bank.sv */
// Single-port SRAM bank, byte strobes and registered read
`timescale 1ns/1ps

module sram_bank (
    input  logic                                clk_i,
    input  mem_island_pkg::narrow_req_t         req_i,
    output logic [mem_island_pkg::NARROW_WIDTH-1:0] rdata_o
);

    logic [mem_island_pkg::NARROW_WIDTH-1:0] mem [mem_island_pkg::WORDS_PER_BANK];
    logic [mem_island_pkg::NARROW_WIDTH-1:0] rdata_q;

    always_ff @(posedge clk_i) begin
        if (req_i.valid) begin
            // Byte-wise write under strobe
            if (req_i.write) begin
                for (int b = 0; b < mem_island_pkg::NARROW_STRB_WIDTH; b++) begin
                    if (req_i.strb[b]) begin
                        mem[req_i.addr.narrow.word][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
                    end
                end
            end
            // Old contents, read-before-write
            rdata_q <= mem[req_i.addr.narrow.word];
        end
    end

    assign rdata_o = rdata_q;

endmodule

/* rtl/tcdm_xbar.sv */
// Requester-to-bank crossbar with per-bank round-robin arbitration
// and one-cycle response routing
`timescale 1ns/1ps

module tcdm_xbar #(
    parameter int unsigned NUM_IN    = 2,
    parameter int unsigned NUM_OUT   = 4,
    parameter bit          WIDE_VIEW = 1'b0,
    parameter type         req_t     = logic,
    parameter type         rsp_t     = logic
) (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  req_t [NUM_IN-1:0]      req_i,
    output rsp_t [NUM_IN-1:0]      rsp_o,
    output req_t [NUM_OUT-1:0]     bank_req_o,
    input  logic [NUM_OUT-1:0]     bank_ready_i,
    // Response minus gnt and rvalid is the rdata word
    input  logic [NUM_OUT-1:0][$bits(rsp_t)-3:0] bank_rdata_i
);

    localparam int unsigned SEL_WIDTH = (NUM_OUT > 1) ? $clog2(NUM_OUT) : 1;
    localparam int unsigned IDX_WIDTH = (NUM_IN > 1) ? $clog2(NUM_IN) : 1;

    logic [NUM_IN-1:0][SEL_WIDTH-1:0]  sel;
    logic [NUM_OUT-1:0][IDX_WIDTH-1:0] rr_q;
    logic [NUM_OUT-1:0]                win_valid;
    logic [NUM_OUT-1:0][IDX_WIDTH-1:0] win_idx;
    logic [NUM_IN-1:0]                 port_gnt;
    // Bank was accessed last cycle, and by which port
    logic [NUM_OUT-1:0]                gnt_q;
    logic [NUM_OUT-1:0][IDX_WIDTH-1:0] port_q;

    // ------------------------------------------------------------------------
    // Bank decode from the chosen address view
    // ------------------------------------------------------------------------
    for (genvar p = 0; p < NUM_IN; p++) begin : g_sel
        if (WIDE_VIEW) begin : g_wide
            assign sel[p] = req_i[p].addr.wide.bank;
        end else begin : g_narrow
            assign sel[p] = req_i[p].addr.narrow.bank;
        end
    end

    // Round-robin pick per bank, starting at the pointer
    always_comb begin
        int unsigned idx;
        win_valid  = '0;
        win_idx    = '0;
        bank_req_o = '0;
        port_gnt   = '0;
        for (int b = 0; b < NUM_OUT; b++) begin
            for (int k = 0; k < NUM_IN; k++) begin
                idx = (32'(rr_q[b]) + k) % NUM_IN;
                if (!win_valid[b] && req_i[idx].valid && sel[idx] == SEL_WIDTH'(b)) begin
                    win_valid[b] = 1'b1;
                    win_idx[b]   = IDX_WIDTH'(idx);
                end
            end
            // Valid goes out even when not ready, the narrow/wide arbiter needs it
            if (win_valid[b]) begin
                bank_req_o[b] = req_i[win_idx[b]];
                if (bank_ready_i[b]) begin
                    port_gnt[win_idx[b]] = 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Pointer and grant tracking
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rr_q  <= '0;
            gnt_q <= '0;
        end else begin
            for (int b = 0; b < NUM_OUT; b++) begin
                gnt_q[b] <= win_valid[b] & bank_ready_i[b];
                // Move past the port just served
                if (win_valid[b] && bank_ready_i[b]) begin
                    rr_q[b] <= (win_idx[b] == IDX_WIDTH'(NUM_IN - 1)) ? '0
                                                                      : win_idx[b] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        port_q <= win_idx;
    end

    // Grant now, rvalid and rdata one cycle later
    always_comb begin
        for (int p = 0; p < NUM_IN; p++) begin
            rsp_o[p]     = '0;
            rsp_o[p].gnt = port_gnt[p];
        end
        for (int b = 0; b < NUM_OUT; b++) begin
            if (gnt_q[b]) begin
                rsp_o[port_q[b]].rvalid = 1'b1;
                rsp_o[port_q[b]].rdata  = bank_rdata_i[b];
            end
        end
    end

endmodule

/* rtl/wide_narrow_arbiter.sv */
// Per bank pair arbitration between the narrow and the wide crossbar
`timescale 1ns/1ps

module wide_narrow_arbiter (
    input  logic                                        clk_i,
    input  logic                                        reset_i,
    input  logic [mem_island_pkg::NUM_NARROW_BANKS-1:0] narrow_valid_i,
    input  logic [mem_island_pkg::NUM_WIDE_BANKS-1:0]   wide_valid_i,
    output logic [mem_island_pkg::NUM_NARROW_BANKS-1:0] narrow_ready_o,
    output logic [mem_island_pkg::NUM_WIDE_BANKS-1:0]   wide_ready_o
);

    // Priority bit per pair, 0 favours narrow
    logic [mem_island_pkg::NUM_WIDE_BANKS-1:0] prio_q;
    logic [mem_island_pkg::NUM_WIDE_BANKS-1:0] narrow_any;
    logic [mem_island_pkg::NUM_WIDE_BANKS-1:0] contend;
    logic [mem_island_pkg::NUM_WIDE_BANKS-1:0] wide_win;

    // ------------------------------------------------------------------------
    // Pair ownership
    // ------------------------------------------------------------------------
    always_comb begin
        for (int w = 0; w < mem_island_pkg::NUM_WIDE_BANKS; w++) begin
            // Narrow side contends if it hits either bank of the pair
            narrow_any[w] = |narrow_valid_i[w*mem_island_pkg::WIDE_FACTOR +:
                                            mem_island_pkg::WIDE_FACTOR];
            contend[w]    = narrow_any[w] & wide_valid_i[w];
            // Uncontended wide request wins outright
            wide_win[w]   = contend[w] ? prio_q[w] : wide_valid_i[w];
        end
    end

    assign wide_ready_o = wide_win;

    // Both narrow banks of a pair follow the pair outcome
    always_comb begin
        for (int i = 0; i < mem_island_pkg::NUM_NARROW_BANKS; i++) begin
            narrow_ready_o[i] = ~wide_win[i / mem_island_pkg::WIDE_FACTOR];
        end
    end

    // Flip after every contended cycle
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            prio_q <= '0;
        end else begin
            for (int w = 0; w < mem_island_pkg::NUM_WIDE_BANKS; w++) begin
                if (contend[w]) begin
                    prio_q[w] <= ~prio_q[w];
                end
            end
        end
    end

endmodule

/* rtl/wide_splitter.sv */
// Wide request to narrow lane requests, lane read data back to a wide word
`timescale 1ns/1ps

module wide_splitter (
    input  mem_island_pkg::wide_req_t                                   wide_req_i,
    output mem_island_pkg::narrow_req_t [mem_island_pkg::WIDE_FACTOR-1:0] bank_req_o,
    input  logic [mem_island_pkg::WIDE_FACTOR-1:0][mem_island_pkg::NARROW_WIDTH-1:0]
                                                                        bank_rdata_i,
    output logic [mem_island_pkg::WIDE_WIDTH-1:0]                       wide_rdata_o
);

    // ------------------------------------------------------------------------
    // Lane split
    // ------------------------------------------------------------------------
    // Lane 0 lands on the even bank of the pair, lane 1 on the odd one.
    // Every lane carries valid, even with an empty strobe, so the pair is
    // always used as a whole.
    always_comb begin
        for (int l = 0; l < mem_island_pkg::WIDE_FACTOR; l++) begin
            bank_req_o[l]                  = '0;
            bank_req_o[l].valid            = wide_req_i.valid;
            bank_req_o[l].write            = wide_req_i.write;
            // Same in-bank word, bank rebuilt as pair select plus lane
            bank_req_o[l].addr.narrow.word = wide_req_i.addr.wide.word;
            bank_req_o[l].addr.narrow.bank = {wide_req_i.addr.wide.bank,
                                              mem_island_pkg::LANE_SEL_WIDTH'(l)};
            bank_req_o[l].wdata = wide_req_i.wdata[l*mem_island_pkg::NARROW_WIDTH +:
                                                   mem_island_pkg::NARROW_WIDTH];
            bank_req_o[l].strb  = wide_req_i.strb[l*mem_island_pkg::NARROW_STRB_WIDTH +:
                                                  mem_island_pkg::NARROW_STRB_WIDTH];
        end
    end

    // Merge, low lane in the low half
    always_comb begin
        for (int l = 0; l < mem_island_pkg::WIDE_FACTOR; l++) begin
            wide_rdata_o[l*mem_island_pkg::NARROW_WIDTH +: mem_island_pkg::NARROW_WIDTH] =
                bank_rdata_i[l];
        end
    end

endmodule

/* verif/mem_island_tb.sv */
// Memory island testbench, clock and reset, directed and random stimulus,
// byte-array reference model, response compare process and watchdog
`timescale 1ns/1ps

module mem_island_tb;

    // Ports 0 and 1 are narrow, ports 2 and 3 are wide
    localparam int NUM_PORTS = 4;
    localparam int RAND_TXNS = 40;
    // Fill, directed sections, random section
    localparam int NUM_TXNS  = 128 + 5 + 5 + 8 + 8 + NUM_PORTS * RAND_TXNS;

    // Common view of a narrow or wide port
    typedef struct packed {
        logic                                    valid;
        logic                                    write;
        logic [mem_island_pkg::ADDR_WIDTH-1:0]   addr;
        logic [mem_island_pkg::WIDE_WIDTH-1:0]   wdata;
        logic [mem_island_pkg::WIDE_WIDTH/8-1:0] strb;
    } port_req_t;

    typedef struct packed {
        logic                                  gnt;
        logic                                  rvalid;
        logic [mem_island_pkg::WIDE_WIDTH-1:0] rdata;
    } port_rsp_t;

    logic                          clk;
    logic                          reset;
    port_req_t [NUM_PORTS-1:0]     port_req;
    port_rsp_t [NUM_PORTS-1:0]     port_rsp;
    mem_island_pkg::narrow_req_t [mem_island_pkg::NUM_NARROW_PORTS-1:0] narrow_req;
    mem_island_pkg::narrow_rsp_t [mem_island_pkg::NUM_NARROW_PORTS-1:0] narrow_rsp;
    mem_island_pkg::wide_req_t   [mem_island_pkg::NUM_WIDE_PORTS-1:0]   wide_req;
    mem_island_pkg::wide_rsp_t   [mem_island_pkg::NUM_WIDE_PORTS-1:0]   wide_rsp;

    // Reference memory, one entry per byte address
    logic [7:0]                    mem_model [1024];
    // Expected response per port, one cycle deep
    logic [NUM_PORTS-1:0]          pend_valid = '0;
    logic [NUM_PORTS-1:0]          pend_read  = '0;
    logic [NUM_PORTS-1:0][63:0]    pend_data  = '0;

    for (genvar p = 0; p < 2; p++) begin : g_ports
        assign narrow_req[p] = {port_req[p].valid, port_req[p].write, port_req[p].addr,
                                port_req[p].wdata[31:0], port_req[p].strb[3:0]};
        assign wide_req[p]   = {port_req[p+2].valid, port_req[p+2].write, port_req[p+2].addr,
                                port_req[p+2].wdata, port_req[p+2].strb};
        assign port_rsp[p]   = {narrow_rsp[p].gnt, narrow_rsp[p].rvalid, 32'h0,
                                narrow_rsp[p].rdata};
        assign port_rsp[p+2] = {wide_rsp[p].gnt, wide_rsp[p].rvalid, wide_rsp[p].rdata};
    end

    mem_island_core uut (
        .clk_i        (clk),
        .reset_i      (reset),
        .narrow_req_i (narrow_req),
        .narrow_rsp_o (narrow_rsp),
        .wide_req_i   (wide_req),
        .wide_rsp_o   (wide_rsp)
    );

    always #50 clk = ~clk;

    // ------------------------------------------------------------------------
    // Reporting and reference model
    // ------------------------------------------------------------------------
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    function automatic string port_name(input int p);
        return (p < 2) ? $sformatf("narrow_rsp_o[%0d]", p) : $sformatf("wide_rsp_o[%0d]", p - 2);
    endfunction

    // Aligned read of 4 or 8 bytes, narrow and wide views share one byte map
    function automatic logic [63:0] ref_read(input logic [9:0] addr, input int nbytes);
        logic [63:0] data;
        logic [9:0]  base;
        data = '0;
        base = addr & ~10'(nbytes - 1);
        for (int k = 0; k < nbytes; k++) begin
            data[k*8 +: 8] = mem_model[base + 10'(k)];
        end
        return data;
    endfunction

    task automatic model_write(input logic [9:0] addr, input int nbytes,
                               input logic [63:0] wdata, input logic [7:0] strb);
        logic [9:0] base;
        base = addr & ~10'(nbytes - 1);
        for (int k = 0; k < nbytes; k++) begin
            if (strb[k]) begin
                mem_model[base + 10'(k)] = wdata[k*8 +: 8];
            end
        end
    endtask

    // Fill byte, every address bit takes part
    function automatic logic [7:0] fill_byte(input logic [9:0] a);
        return a[7:0] ^ {a[9:8], a[9:8], a[9:8], a[9:8]} ^ 8'h5a;
    endfunction

    // ------------------------------------------------------------------------
    // Drivers
    // ------------------------------------------------------------------------
    // Entered at posedge + 1 ns, leaves at posedge + 1 ns after the grant edge
    task automatic access(input int port, input logic write, input logic [9:0] addr,
                          input logic [63:0] wdata, input logic [7:0] strb, input int max_wait);
        int waits;
        port_req[port] = {1'b1, write, addr, wdata, strb};
        waits = 0;
        @(negedge clk);
        while (!port_rsp[port].gnt && waits < max_wait) begin
            waits++;
            @(negedge clk);
        end
        if (!port_rsp[port].gnt) begin
            abort_run($sformatf("No grant on %s within %0d cycles", port_name(port),
                                max_wait + 1));
        end else begin
            @(posedge clk);
            #1;
            port_req[port] = '0;
        end
    endtask

    task automatic random_traffic(input int port, input int count);
        int idle;
        for (int n = 0; n < count; n++) begin
            idle = $urandom_range(0, 2);
            if (idle != 0) begin
                repeat (idle) @(posedge clk);
                #1;
            end
            access(port, 1'($urandom_range(0, 1)), 10'($urandom), {$urandom, $urandom},
                   8'($urandom), 4);
        end
    endtask

    task automatic fill_pair(input int port, input logic pair);
        logic [9:0]  a;
        logic [63:0] d;
        for (int w = 0; w < mem_island_pkg::WORDS_PER_BANK; w++) begin
            a = {6'(w), pair, 3'b000};
            for (int k = 0; k < 8; k++) begin
                d[k*8 +: 8] = fill_byte(a + 10'(k));
            end
            access(port, 1'b1, a, d, 8'hff, 4);
        end
    endtask

    // ------------------------------------------------------------------------
    // Compare process, sampled at the falling edge
    // ------------------------------------------------------------------------
    always @(negedge clk) begin : compare
        logic [9:0] a;
        int         nbytes;
        if (!reset) begin
            // Responses for last cycle's grants
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (pend_valid[p]) begin
                    check_value({port_name(p), ".rvalid"}, 64'(port_rsp[p].rvalid), 64'd1);
                    if (pend_read[p]) begin
                        check_value({port_name(p), ".rdata"}, port_rsp[p].rdata, pend_data[p]);
                    end
                end else if (port_rsp[p].rvalid) begin
                    abort_run($sformatf("Response on %s without a grant", port_name(p)));
                end
            end
            // Grants completing at the next rising edge
            for (int p = 0; p < NUM_PORTS; p++) begin
                pend_valid[p] = port_rsp[p].gnt;
                if (port_rsp[p].gnt && !port_req[p].valid) begin
                    abort_run($sformatf("Grant on %s without a request", port_name(p)));
                end else if (port_rsp[p].gnt) begin
                    a            = port_req[p].addr;
                    nbytes       = (p < 2) ? 4 : 8;
                    pend_read[p] = !port_req[p].write;
                    if (port_req[p].write) begin
                        model_write(a, nbytes, port_req[p].wdata, port_req[p].strb);
                    end else begin
                        pend_data[p] = ref_read(a, nbytes);
                    end
                end
            end
        end
    end

    // Watchdog
    initial begin
        #(NUM_TXNS * 6 * 100);
        abort_run("Timeout, the tests did not finish in time");
    end

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        void'($urandom(32'hd86e5329));
        clk      = 1'b0;
        reset    = 1'b1;
        port_req = '0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        // Idle ports after reset
        @(negedge clk);
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_value({port_name(p), ".gnt"}, 64'(port_rsp[p].gnt), 64'd0);
            check_value({port_name(p), ".rvalid"}, 64'(port_rsp[p].rvalid), 64'd0);
        end
        @(posedge clk);
        #1;

        // Whole memory through both wide ports
        fork
            fill_pair(2, 1'b0);
            fill_pair(3, 1'b1);
        join

        // Partial strobe merges on narrow ports
        access(0, 1'b1, 10'h048, 64'hdeadbeef, 8'h0f, 4);
        access(0, 1'b1, 10'h048, 64'h11223344, 8'h05, 4);
        access(0, 1'b0, 10'h048, 64'h0, 8'h0, 4);
        access(1, 1'b1, 10'h04c, 64'h99aabbcc, 8'h08, 4);
        access(1, 1'b0, 10'h04c, 64'h0, 8'h0, 4);

        // Wide lanes against narrow banks of pair 1, then the reverse
        access(3, 1'b1, 10'h0a8, 64'h1122334455667788, 8'hff, 4);
        access(0, 1'b0, 10'h0a8, 64'h0, 8'h0, 4);
        access(1, 1'b0, 10'h0ac, 64'h0, 8'h0, 4);
        access(1, 1'b1, 10'h0c4, 64'hcafe0123, 8'h03, 4);
        access(2, 1'b0, 10'h0c0, 64'h0, 8'h0, 4);

        // Two narrow ports held on bank 1
        fork
            for (int n = 0; n < 4; n++) begin
                access(0, n[0], 10'h004 + 10'(n * 16), 64'(n) * 64'h01010101, 8'h0f, 1);
            end
            for (int n = 0; n < 4; n++) begin
                access(1, 1'b0, 10'h104 + 10'(n * 16), 64'h0, 8'h0, 1);
            end
        join

        // Narrow and wide held on pair 0
        fork
            for (int n = 0; n < 4; n++) begin
                access(0, n[0], 10'h020 + 10'(n * 16), 64'h5a5a0000 + 64'(n), 8'h0f, 1);
            end
            for (int n = 0; n < 4; n++) begin
                access(2, !n[0], 10'h230 + 10'(n * 16), {32'(n), 32'hf00d}, 8'hff, 1);
            end
        join

        // Mixed random traffic
        fork
            random_traffic(0, RAND_TXNS);
            random_traffic(1, RAND_TXNS);
            random_traffic(2, RAND_TXNS);
            random_traffic(3, RAND_TXNS);
        join

        // Last responses
        repeat (2) @(negedge clk);
        $display("TEST PASS");
        $finish;
    end

endmodule
